/* rtl/icache_settings.svh */
`ifndef ICACHE_SETTINGS_SVH
`define ICACHE_SETTINGS_SVH

// fetch address split into tag, index and offset
`define ICACHE_ADDR_W      32
`define ICACHE_OFFSET_W    4
`define ICACHE_INDEX_W     7
`define ICACHE_TAG_W       21

// one line is two doublewords
`define ICACHE_LINE_W      128
`define ICACHE_WORD_W      64

// each way is split over two banks by the top index bit
`define ICACHE_BANK_DEPTH  64
`define ICACHE_BANK_AW     6

`endif

/* rtl/icache_pkg.sv */
package icache_pkg;

    // way number within a set
    typedef enum logic {
        WAY0 = 1'b0,
        WAY1 = 1'b1
    } way_e;

    // controller states
    // HIT returns data for the request accepted one cycle before
    typedef enum logic [2:0] {
        IDLE   = 3'd0,
        HIT    = 3'd1,
        MISS   = 3'd2,
        DATA   = 3'd3,
        REFILL = 3'd4
    } cache_state_e;

endpackage

/* rtl/icache_tag_dir.sv */
`timescale 1ns/1ns
`include "icache_settings.svh"

module icache_tag_dir (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [`ICACHE_ADDR_W-1:0]   i_addr,
    input  logic                        i_accept,
    input  logic                        i_fill_en,
    input  icache_pkg::way_e            i_fill_way,
    input  logic [`ICACHE_INDEX_W-1:0]  i_fill_index,
    input  logic [`ICACHE_TAG_W-1:0]    i_fill_tag,
    output logic                        o_hit0,
    output logic                        o_hit1,
    output icache_pkg::way_e            o_victim_way
);

    localparam int SETS = 1 << `ICACHE_INDEX_W;

    logic [`ICACHE_TAG_W-1:0]   tag_q [2][SETS];
    logic [SETS-1:0]            valid_q [2];
    icache_pkg::way_e           mru_q [SETS];

    logic [`ICACHE_TAG_W-1:0]   req_tag;
    logic [`ICACHE_INDEX_W-1:0] req_index;
    logic [1:0]                 way_valid;
    logic [1:0]                 way_hit;
    logic                       fill_sel;
    icache_pkg::way_e           touch_way;

    assign req_tag   = i_addr[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W];
    assign req_index = i_addr[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];
    assign fill_sel  = (i_fill_way == icache_pkg::WAY1);

    // combinational lookup on the incoming address
    always_comb begin
        for (int w = 0; w < 2; w++) begin
            way_valid[w] = valid_q[w][req_index];
            way_hit[w]   = valid_q[w][req_index] && (tag_q[w][req_index] == req_tag);
        end
    end

    assign o_hit0 = way_hit[0];
    assign o_hit1 = way_hit[1];

    // invalid way first, then the one not most recently used
    always_comb begin
        if (!way_valid[0]) begin
            o_victim_way = icache_pkg::WAY0;
        end else if (!way_valid[1]) begin
            o_victim_way = icache_pkg::WAY1;
        end else if (mru_q[req_index] == icache_pkg::WAY0) begin
            o_victim_way = icache_pkg::WAY1;
        end else begin
            o_victim_way = icache_pkg::WAY0;
        end
    end

    // a miss marks the way it is about to fill
    always_comb begin
        if (way_hit[1]) begin
            touch_way = icache_pkg::WAY1;
        end else if (way_hit[0]) begin
            touch_way = icache_pkg::WAY0;
        end else begin
            touch_way = o_victim_way;
        end
    end

    always_ff @(posedge clk) begin
        if (i_fill_en) begin
            tag_q[fill_sel][i_fill_index] <= i_fill_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q[0] <= '0;
            valid_q[1] <= '0;
        end else if (i_fill_en) begin
            valid_q[fill_sel][i_fill_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < SETS; s++) begin
                mru_q[s] <= icache_pkg::WAY0;
            end
        end else if (i_accept) begin
            mru_q[req_index] <= touch_way;
        end
    end

endmodule

/* rtl/icache_data_ram.sv */
`timescale 1ns/1ns
`include "icache_settings.svh"

module icache_data_ram (
    input  logic                        clk,
    input  logic [`ICACHE_INDEX_W-1:0]  i_rd_index,
    input  logic                        i_accept,
    input  logic                        i_wr_en,
    input  icache_pkg::way_e            i_wr_way,
    input  logic [`ICACHE_INDEX_W-1:0]  i_wr_index,
    input  logic [`ICACHE_LINE_W-1:0]   i_wr_line,
    output logic [`ICACHE_LINE_W-1:0]   o_line0,
    output logic [`ICACHE_LINE_W-1:0]   o_line1
);

    // banks ordered way0 low, way0 high, way1 low, way1 high
    logic [`ICACHE_LINE_W-1:0]  rd_q [4];
    logic [`ICACHE_BANK_AW-1:0] rd_addr;
    logic [`ICACHE_BANK_AW-1:0] wr_addr;
    logic                       rd_hi;
    logic                       wr_hi;
    logic                       wr_way1;
    logic                       rd_hi_q;

    assign rd_addr = i_rd_index[`ICACHE_BANK_AW-1:0];
    assign wr_addr = i_wr_index[`ICACHE_BANK_AW-1:0];
    assign rd_hi   = i_rd_index[`ICACHE_INDEX_W-1];
    assign wr_hi   = i_wr_index[`ICACHE_INDEX_W-1];
    assign wr_way1 = (i_wr_way == icache_pkg::WAY1);

    genvar b;
    generate
        for (b = 0; b < 4; b++) begin : g_bank
            localparam logic [1:0] BANK_ID = 2'(b);

            logic [`ICACHE_LINE_W-1:0] mem [`ICACHE_BANK_DEPTH];
            logic                      wr_sel;
            logic                      rd_sel;

            assign wr_sel = i_wr_en && (wr_way1 == BANK_ID[1]) && (wr_hi == BANK_ID[0]);
            assign rd_sel = i_accept && (rd_hi == BANK_ID[0]);

            // write wins over a read of the same bank
            always_ff @(posedge clk) begin
                if (wr_sel) begin
                    mem[wr_addr] <= i_wr_line;
                end else if (rd_sel) begin
                    rd_q[b] <= mem[rd_addr];
                end
            end
        end
    endgenerate

    // remember which half the pending read came from
    always_ff @(posedge clk) begin
        if (i_accept) begin
            rd_hi_q <= rd_hi;
        end
    end

    assign o_line0 = rd_hi_q ? rd_q[1] : rd_q[0];
    assign o_line1 = rd_hi_q ? rd_q[3] : rd_q[2];

endmodule

/* rtl/icache_ctrl.sv */
`timescale 1ns/1ns
`include "icache_settings.svh"

module icache_ctrl (
    input  logic                        clk,
    input  logic                        rst,
    // fetch side
    input  logic [`ICACHE_ADDR_W-1:0]   i_addr,
    input  logic                        i_req,
    output logic                        o_ready,
    output logic                        o_accept,
    // directory and data store results
    input  logic                        i_hit0,
    input  logic                        i_hit1,
    input  icache_pkg::way_e            i_victim_way,
    input  logic [`ICACHE_LINE_W-1:0]   i_line0,
    input  logic [`ICACHE_LINE_W-1:0]   i_line1,
    // refill
    output logic                        o_fill_en,
    output icache_pkg::way_e            o_fill_way,
    output logic [`ICACHE_INDEX_W-1:0]  o_fill_index,
    output logic [`ICACHE_TAG_W-1:0]    o_fill_tag,
    output logic [`ICACHE_LINE_W-1:0]   o_fill_line,
    // response
    output logic [`ICACHE_WORD_W-1:0]   o_rdata,
    output logic                        o_valid,
    // memory read burst
    output logic                        o_axi_rd_req,
    output logic [`ICACHE_ADDR_W-1:0]   o_axi_rd_addr,
    input  logic                        i_axi_rd_ready,
    input  logic [`ICACHE_WORD_W-1:0]   i_axi_rdata,
    input  logic                        i_axi_rvalid,
    input  logic                        i_axi_rlast,
    // perf counting
    output logic                        o_hit_pulse,
    output logic                        o_req_pulse
);

    icache_pkg::cache_state_e state_q;
    icache_pkg::cache_state_e state_d;

    logic                       accept;
    logic                       hit;

    // request buffer
    logic [`ICACHE_ADDR_W-1:0]  addr_q;
    logic                       hit0_q;
    logic                       hit1_q;
    icache_pkg::way_e           victim_q;

    // burst assembly
    logic                       beat_q;
    logic [`ICACHE_LINE_W-1:0]  line_q;

    logic [`ICACHE_LINE_W-1:0]  hit_line;
    logic [`ICACHE_LINE_W-1:0]  src_line;

    assign o_ready  = (state_q == icache_pkg::IDLE) || (state_q == icache_pkg::HIT);
    assign accept   = i_req && o_ready;
    assign hit      = i_hit0 || i_hit1;
    assign o_accept = accept;

    assign o_req_pulse = accept;
    assign o_hit_pulse = accept && hit;

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q   <= i_addr;
            hit0_q   <= i_hit0;
            hit1_q   <= i_hit1;
            victim_q <= i_victim_way;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            icache_pkg::IDLE, icache_pkg::HIT: begin
                if (accept) begin
                    state_d = hit ? icache_pkg::HIT : icache_pkg::MISS;
                end else begin
                    state_d = icache_pkg::IDLE;
                end
            end
            icache_pkg::MISS: begin
                if (i_axi_rd_ready) begin
                    state_d = icache_pkg::DATA;
                end
            end
            icache_pkg::DATA: begin
                if (i_axi_rvalid && i_axi_rlast) begin
                    state_d = icache_pkg::REFILL;
                end
            end
            icache_pkg::REFILL: begin
                state_d = icache_pkg::IDLE;
            end
            default: begin
                state_d = icache_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= icache_pkg::IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    assign o_axi_rd_req  = (state_q == icache_pkg::MISS);
    assign o_axi_rd_addr = {addr_q[`ICACHE_ADDR_W-1:`ICACHE_OFFSET_W], {`ICACHE_OFFSET_W{1'b0}}};

    // beat count restarts when the burst is granted
    always_ff @(posedge clk) begin
        if (rst) begin
            beat_q <= 1'b0;
        end else if (o_axi_rd_req && i_axi_rd_ready) begin
            beat_q <= 1'b0;
        end else if ((state_q == icache_pkg::DATA) && i_axi_rvalid) begin
            beat_q <= ~beat_q;
        end
    end

    // lower doubleword arrives first
    always_ff @(posedge clk) begin
        if ((state_q == icache_pkg::DATA) && i_axi_rvalid) begin
            if (beat_q) begin
                line_q[`ICACHE_LINE_W-1:`ICACHE_WORD_W] <= i_axi_rdata;
            end else begin
                line_q[`ICACHE_WORD_W-1:0] <= i_axi_rdata;
            end
        end
    end

    assign o_fill_en    = (state_q == icache_pkg::REFILL);
    assign o_fill_way   = victim_q;
    assign o_fill_index = addr_q[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];
    assign o_fill_tag   = addr_q[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W];
    assign o_fill_line  = line_q;

    assign hit_line = ({`ICACHE_LINE_W{hit0_q}} & i_line0)
                    | ({`ICACHE_LINE_W{hit1_q}} & i_line1);
    assign src_line = (state_q == icache_pkg::REFILL) ? line_q : hit_line;

    // offset bit 3 picks the doubleword
    assign o_rdata = addr_q[`ICACHE_OFFSET_W-1] ? src_line[`ICACHE_LINE_W-1:`ICACHE_WORD_W]
                                                : src_line[`ICACHE_WORD_W-1:0];
    assign o_valid = (state_q == icache_pkg::HIT) || (state_q == icache_pkg::REFILL);

endmodule

/* rtl/icache_top.sv */
`timescale 1ns/1ns
`include "icache_settings.svh"

module icache_top (
    input  logic                        clk,
    input  logic                        rst,
    // fetch request
    input  logic [`ICACHE_ADDR_W-1:0]   i_addr,
    input  logic                        i_req,
    output logic                        o_ready,
    // fetch response
    output logic [`ICACHE_WORD_W-1:0]   o_rdata,
    output logic                        o_valid,
    // memory read burst
    output logic                        o_axi_rd_req,
    output logic [`ICACHE_ADDR_W-1:0]   o_axi_rd_addr,
    input  logic                        i_axi_rd_ready,
    input  logic [`ICACHE_WORD_W-1:0]   i_axi_rdata,
    input  logic                        i_axi_rvalid,
    input  logic                        i_axi_rlast,
    // perf counting
    output logic                        o_hit_pulse,
    output logic                        o_req_pulse
);

    logic                       accept;
    logic                       hit0;
    logic                       hit1;
    icache_pkg::way_e           victim_way;
    logic [`ICACHE_LINE_W-1:0]  line0;
    logic [`ICACHE_LINE_W-1:0]  line1;
    logic                       fill_en;
    icache_pkg::way_e           fill_way;
    logic [`ICACHE_INDEX_W-1:0] fill_index;
    logic [`ICACHE_TAG_W-1:0]   fill_tag;
    logic [`ICACHE_LINE_W-1:0]  fill_line;

    icache_tag_dir u_tag_dir (
        .clk          (clk),
        .rst          (rst),
        .i_addr       (i_addr),
        .i_accept     (accept),
        .i_fill_en    (fill_en),
        .i_fill_way   (fill_way),
        .i_fill_index (fill_index),
        .i_fill_tag   (fill_tag),
        .o_hit0       (hit0),
        .o_hit1       (hit1),
        .o_victim_way (victim_way)
    );

    icache_data_ram u_data_ram (
        .clk        (clk),
        .i_rd_index (i_addr[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W]),
        .i_accept   (accept),
        .i_wr_en    (fill_en),
        .i_wr_way   (fill_way),
        .i_wr_index (fill_index),
        .i_wr_line  (fill_line),
        .o_line0    (line0),
        .o_line1    (line1)
    );

    icache_ctrl u_ctrl (
        .clk            (clk),
        .rst            (rst),
        .i_addr         (i_addr),
        .i_req          (i_req),
        .o_ready        (o_ready),
        .o_accept       (accept),
        .i_hit0         (hit0),
        .i_hit1         (hit1),
        .i_victim_way   (victim_way),
        .i_line0        (line0),
        .i_line1        (line1),
        .o_fill_en      (fill_en),
        .o_fill_way     (fill_way),
        .o_fill_index   (fill_index),
        .o_fill_tag     (fill_tag),
        .o_fill_line    (fill_line),
        .o_rdata        (o_rdata),
        .o_valid        (o_valid),
        .o_axi_rd_req   (o_axi_rd_req),
        .o_axi_rd_addr  (o_axi_rd_addr),
        .i_axi_rd_ready (i_axi_rd_ready),
        .i_axi_rdata    (i_axi_rdata),
        .i_axi_rvalid   (i_axi_rvalid),
        .i_axi_rlast    (i_axi_rlast),
        .o_hit_pulse    (o_hit_pulse),
        .o_req_pulse    (o_req_pulse)
    );

endmodule

/* testbench/axi_mem_model.sv */
`timescale 1ns/1ns

module axi_mem_model #(
    parameter int MAX_WAIT = 3
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        i_rd_req,
    input  logic [31:0] i_rd_addr,
    output logic        o_rd_ready,
    output logic [63:0] o_rdata,
    output logic        o_rvalid,
    output logic        o_rlast
);

    integer      seed = 32'hba4f_5c5b;
    logic [31:0] base;
    logic [31:0] dw_addr;

    function automatic int pick_wait();
        return $unsigned($random(seed)) % (MAX_WAIT + 1);
    endfunction

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    // two-beat burst per request with the lower doubleword first
    initial begin
        o_rd_ready = 1'b0;
        o_rdata    = '0;
        o_rvalid   = 1'b0;
        o_rlast    = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            if (!rst && i_rd_req) begin
                base = {i_rd_addr[31:4], 4'h0};
                idle_cycles(pick_wait());
                o_rd_ready = 1'b1;
                idle_cycles(1);
                o_rd_ready = 1'b0;
                for (int beat = 0; beat < 2; beat++) begin
                    idle_cycles(pick_wait());
                    dw_addr  = base + 32'(beat * 8);
                    // inverted address on top, address below
                    o_rdata  = {~dw_addr, dw_addr};
                    o_rvalid = 1'b1;
                    o_rlast  = (beat == 1);
                    idle_cycles(1);
                    o_rvalid = 1'b0;
                    o_rlast  = 1'b0;
                end
            end
        end
    end

endmodule

/* testbench/tb_icache.sv */
`timescale 1ns/1ns
`include "icache_settings.svh"

module tb_icache;

    localparam int CLK_NS     = 8;
    localparam int MAX_WAIT   = 3;
    // requests issued over all six tests
    localparam int N_REQ      = 37;
    localparam int REQ_CYCLES = 3 * (MAX_WAIT + 2) + 6;
    localparam int TIMEOUT_NS = (N_REQ * REQ_CYCLES + 40) * CLK_NS;

    localparam logic [31:0] LINE_A = 32'h0000_1004;
    localparam logic [31:0] LINE_B = 32'h0000_2010;
    // three tags sharing set 5
    localparam logic [31:0] SET_X  = 32'h0001_0050;
    localparam logic [31:0] SET_Y  = 32'h0002_0050;
    localparam logic [31:0] SET_Z  = 32'h0003_0050;
    localparam logic [31:0] B2B [6] = '{32'h0000_1004, 32'h0000_100c, 32'h0000_2010,
                                        32'h0000_2018, SET_Z, SET_Y};

    logic        clk = 1'b0;
    logic        rst;
    logic [31:0] addr;
    logic        req;
    logic        ready;
    logic [63:0] rdata;
    logic        valid;
    logic        rd_req;
    logic [31:0] rd_addr;
    logic        rd_ready;
    logic [63:0] axi_rdata;
    logic        axi_rvalid;
    logic        axi_rlast;
    logic        hit_pulse;
    logic        req_pulse;

    // expected data pushed at issue and popped on o_valid
    logic [63:0] exp_mem [256];
    logic [31:0] exp_head;
    logic [31:0] exp_tail;
    logic [63:0] exp_front;
    logic        exp_hit;
    logic [31:0] miss_addr;

    // reference tags, valid bits and mru per set
    logic [`ICACHE_TAG_W-1:0] ref_tag [2][128];
    logic                     ref_valid [2][128];
    logic                     ref_mru [128];

    int chk_errors;
    int sva_errors;
    int last_errors;
    int issued;
    int hits_expected;
    int req_count;
    int hit_count;

    always #(CLK_NS / 2) clk = ~clk;

    icache_top dut (
        .clk            (clk),
        .rst            (rst),
        .i_addr         (addr),
        .i_req          (req),
        .o_ready        (ready),
        .o_rdata        (rdata),
        .o_valid        (valid),
        .o_axi_rd_req   (rd_req),
        .o_axi_rd_addr  (rd_addr),
        .i_axi_rd_ready (rd_ready),
        .i_axi_rdata    (axi_rdata),
        .i_axi_rvalid   (axi_rvalid),
        .i_axi_rlast    (axi_rlast),
        .o_hit_pulse    (hit_pulse),
        .o_req_pulse    (req_pulse)
    );

    axi_mem_model #(.MAX_WAIT(MAX_WAIT)) u_mem (
        .clk        (clk),
        .rst        (rst),
        .i_rd_req   (rd_req),
        .i_rd_addr  (rd_addr),
        .o_rd_ready (rd_ready),
        .o_rdata    (axi_rdata),
        .o_rvalid   (axi_rvalid),
        .o_rlast    (axi_rlast)
    );

    assign exp_front = exp_mem[exp_head[7:0]];

    always @(posedge clk) begin
        if (rst) begin
            exp_head  <= '0;
            req_count <= 0;
            hit_count <= 0;
        end else begin
            if (valid) begin
                exp_head <= exp_head + 32'd1;
            end
            if (req_pulse) begin
                req_count <= req_count + 1;
            end
            if (hit_pulse) begin
                hit_count <= hit_count + 1;
            end
        end
    end

    a_extra: assert property (@(posedge clk) disable iff (rst) valid |-> exp_head != exp_tail)
        else begin
            sva_errors++;
            $display("o_valid pulsed with no request outstanding");
        end
    a_rdata: assert property (@(posedge clk) disable iff (rst)
                              valid && exp_head != exp_tail |-> rdata == exp_front)
        else begin
            sva_errors++;
            $display("Mismatch o_rdata: got %h expected %h", $sampled(rdata),
                     $sampled(exp_front));
        end
    a_hit: assert property (@(posedge clk) disable iff (rst) req_pulse |-> hit_pulse == exp_hit)
        else begin
            sva_errors++;
            $display("Mismatch o_hit_pulse: got %h expected %h", $sampled(hit_pulse),
                     $sampled(exp_hit));
        end
    a_hit_lat: assert property (@(posedge clk) disable iff (rst) hit_pulse |=> valid)
        else begin
            sva_errors++;
            $display("o_valid did not follow a hit exactly one cycle later");
        end
    a_miss_lat: assert property (@(posedge clk) disable iff (rst)
                                 req_pulse && !hit_pulse |=> rd_req)
        else begin
            sva_errors++;
            $display("o_axi_rd_req did not rise one cycle after a miss");
        end
    a_burst: assert property (@(posedge clk) disable iff (rst)
                              rd_req |-> rd_addr == {miss_addr[31:4], 4'h0})
        else begin
            sva_errors++;
            $display("Mismatch o_axi_rd_addr: got %h expected %h", $sampled(rd_addr),
                     {$sampled(miss_addr[31:4]), 4'h0});
        end
    a_busy: assert property (@(posedge clk) disable iff (rst) rd_req |-> !ready)
        else begin
            sva_errors++;
            $display("o_ready stayed high during a line fill");
        end

    // invalid way first (way 0 before way 1), else the way not most recently used
    function automatic logic update_ref(input logic [31:0] a);
        logic [`ICACHE_INDEX_W-1:0] idx;
        logic [`ICACHE_TAG_W-1:0]   tag;
        logic                       hit;
        int                         way;
        idx = a[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];
        tag = a[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W];
        hit = 1'b1;
        if (ref_valid[0][idx] && ref_tag[0][idx] == tag) begin
            way = 0;
        end else if (ref_valid[1][idx] && ref_tag[1][idx] == tag) begin
            way = 1;
        end else begin
            hit = 1'b0;
            if (!ref_valid[0][idx]) begin
                way = 0;
            end else if (!ref_valid[1][idx]) begin
                way = 1;
            end else begin
                way = ref_mru[idx] ? 0 : 1;
            end
            ref_valid[way][idx] = 1'b1;
            ref_tag[way][idx]   = tag;
        end
        ref_mru[idx] = (way == 1);
        return hit;
    endfunction

    function automatic logic [63:0] expected_word(input logic [31:0] a);
        logic [31:0] dw_addr;
        dw_addr = {a[31:3], 3'b000};
        return {~dw_addr, dw_addr};
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        assert (got == exp) else begin
            chk_errors++;
            $display("Mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    // single-cycle request issued once o_ready is high
    task automatic fetch(input logic [31:0] a);
        logic hit;
        while (!ready) begin
            @(posedge clk);
            #1;
        end
        hit = update_ref(a);
        exp_mem[exp_tail[7:0]] = expected_word(a);
        exp_tail = exp_tail + 32'd1;
        exp_hit = hit;
        if (!hit) begin
            miss_addr = a;
        end else begin
            hits_expected++;
        end
        issued++;
        req  = 1'b1;
        addr = a;
        @(posedge clk);
        #1;
        req = 1'b0;
    endtask

    task automatic drain();
        while (exp_head != exp_tail) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic end_test(input string name);
        int total;
        total = chk_errors + sva_errors;
        $display("test %-24s %s", name, (total == last_errors) ? "ok" : "fail");
        last_errors = total;
    endtask

    initial begin
        logic [31:0] sweep;
        rst           = 1'b1;
        req           = 1'b0;
        addr          = '0;
        exp_tail      = '0;
        exp_hit       = 1'b0;
        miss_addr     = '0;
        chk_errors    = 0;
        sva_errors    = 0;
        last_errors   = 0;
        issued        = 0;
        hits_expected = 0;
        for (int s = 0; s < 128; s++) begin
            ref_valid[0][s] = 1'b0;
            ref_valid[1][s] = 1'b0;
            ref_mru[s]      = 1'b0;
        end
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        check_value("o_ready", 64'(ready), 64'd1);
        check_value("o_valid", 64'(valid), 64'd0);
        check_value("o_axi_rd_req", 64'(rd_req), 64'd0);
        fetch(LINE_A);
        drain();
        end_test("reset and cold miss");

        fetch(LINE_A);
        fetch(LINE_A);
        drain();
        end_test("repeat hit");

        fetch(LINE_A | 32'h8);
        fetch(LINE_B | 32'h8);
        fetch(LINE_B);
        fetch(LINE_B | 32'h8);
        drain();
        end_test("doubleword select");

        // X and Y fill both ways, Z evicts X, then X evicts Y
        fetch(SET_X);
        fetch(SET_Y);
        fetch(SET_X);
        fetch(SET_Y);
        fetch(SET_Z);
        fetch(SET_X);
        fetch(SET_Z);
        fetch(SET_Y);
        drain();
        end_test("replacement");

        for (int i = 0; i < 6; i++) begin
            check_value("o_ready", 64'(ready), 64'd1);
            fetch(B2B[i]);
        end
        drain();
        end_test("back-to-back hits");

        for (int i = 0; i < 8; i++) begin
            sweep = 32'h0008_0000 + 32'h0000_0410 * 32'(i);
            fetch(sweep);
            fetch(sweep ^ 32'h8);
        end
        drain();
        check_value("o_req_pulse count", 64'(req_count), 64'(issued));
        check_value("o_hit_pulse count", 64'(hit_count), 64'(hits_expected));
        end_test("random waits and counts");

        $display("tests 6, requests %0d, hits %0d, errors %0d", issued, hits_expected,
                 chk_errors + sva_errors);
        if (chk_errors + sva_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired after %0d ns with requests still pending", TIMEOUT_NS);
        $display("TEST FAILED");
        $finish;
    end

endmodule

/* tb.f */
+incdir+rtl
rtl/icache_pkg.sv
rtl/icache_tag_dir.sv
rtl/icache_data_ram.sv
rtl/icache_ctrl.sv
rtl/icache_top.sv
testbench/axi_mem_model.sv
testbench/tb_icache.sv

/* run_sim.sh */
#!/bin/sh
# build and run the icache testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f tb.f --top-module tb_icache \
        -Mdir obj_dir -o sim_icache; then
    echo "verilator build failed"
    exit 1
fi

if ! ./obj_dir/sim_icache > sim.log 2>&1; then
    cat sim.log
    echo "simulation exited with an error"
    exit 1
fi

cat sim.log

if grep -q "^TEST PASSED$" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi
